//--- common/rv_defines.svh
`ifndef RV_DEFINES_SVH
`define RV_DEFINES_SVH

// Major opcodes
`define OP_LOAD     7'b0000011
`define OP_ALU_IMM  7'b0010011
`define OP_AUIPC    7'b0010111
`define OP_STORE    7'b0100011
`define OP_ALU_REG  7'b0110011
`define OP_LUI      7'b0110111
`define OP_BRANCH   7'b1100011
`define OP_JAL      7'b1101111

// ALU operation codes
`define ALU_ADD     4'b0000
`define ALU_SUB     4'b0001
`define ALU_AND     4'b0010
`define ALU_OR      4'b0011
`define ALU_SLL     4'b0100
`define ALU_SLT     4'b0101
`define ALU_SRL     4'b0110
`define ALU_SLTU    4'b0111
`define ALU_XOR     4'b1000
`define ALU_SRA     4'b1001

// Immediate formats
`define IMM_I       3'b000
`define IMM_S       3'b001
`define IMM_B       3'b010
`define IMM_J       3'b011
`define IMM_U       3'b100

// Write-back sources
`define WB_ALU      2'b00
`define WB_MEM      2'b01
`define WB_PC4      2'b10
`define WB_UPPER    2'b11

// First fetch address after reset
`define RESET_PC    32'h0000_0000

`endif

//--- common/rv_pkg.sv
package rv_pkg;

    // Data, addresses and instruction words
    typedef logic [31:0] word_t;

    // Register index into the 32-entry file
    typedef logic [4:0] reg_idx_t;

    // ALU operation code, see ALU_* in rv_defines.svh
    typedef logic [3:0] alu_ctrl_t;

    // Immediate format selector, see IMM_*
    typedef logic [2:0] imm_src_t;

    // Write-back source select, see WB_*
    typedef logic [1:0] wb_src_t;

endpackage

//--- hw/control/control.sv
`timescale 1ns/1ns

`include "rv_defines.svh"

module control (
    input  logic [6:0]          op,
    input  logic [2:0]          funct3,
    input  logic [6:0]          funct7,
    input  logic                alu_zero,
    input  logic                alu_last_bit,
    output rv_pkg::alu_ctrl_t   alu_ctrl,
    output rv_pkg::imm_src_t    imm_src,
    output logic                mem_write,
    output logic                reg_write,
    output logic                alu_src,
    output rv_pkg::wb_src_t     wb_src,
    output logic                pc_src,
    output logic                upper_src
);

    // ALU class handed from main decoder to ALU decoder
    localparam logic [1:0] CLASS_ADD    = 2'b00;
    localparam logic [1:0] CLASS_BRANCH = 2'b01;
    localparam logic [1:0] CLASS_ARITH  = 2'b10;

    logic [1:0] alu_class;
    logic       branch;
    logic       jump;
    logic       take_branch;

    // Main decoder
    always_comb begin
        // Safe defaults, nothing changes state
        alu_class = CLASS_ADD;
        imm_src   = `IMM_I;
        mem_write = 1'b0;
        reg_write = 1'b0;
        alu_src   = 1'b0;
        wb_src    = `WB_ALU;
        branch    = 1'b0;
        jump      = 1'b0;
        upper_src = 1'b0;

        case (op)
            `OP_LOAD: begin
                reg_write = 1'b1;
                alu_src   = 1'b1;
                wb_src    = `WB_MEM;
            end
            `OP_ALU_IMM: begin
                alu_class = CLASS_ARITH;
                alu_src   = 1'b1;
                reg_write = 1'b1;
                // Shift immediates carry funct7 in the upper bits, only a few are legal
                if (funct3 == 3'b001) begin
                    reg_write = (funct7 == 7'b0000000);
                end
                if (funct3 == 3'b101) begin
                    reg_write = (funct7 == 7'b0000000) || (funct7 == 7'b0100000);
                end
            end
            `OP_STORE: begin
                imm_src   = `IMM_S;
                alu_src   = 1'b1;
                mem_write = 1'b1;
            end
            `OP_ALU_REG: begin
                alu_class = CLASS_ARITH;
                reg_write = 1'b1;
            end
            `OP_BRANCH: begin
                alu_class = CLASS_BRANCH;
                imm_src   = `IMM_B;
                branch    = 1'b1;
            end
            `OP_JAL: begin
                imm_src   = `IMM_J;
                reg_write = 1'b1;
                wb_src    = `WB_PC4;
                jump      = 1'b1;
            end
            `OP_LUI, `OP_AUIPC: begin
                imm_src   = `IMM_U;
                reg_write = 1'b1;
                wb_src    = `WB_UPPER;
                // High selects a zero base (LUI), low the PC (AUIPC)
                upper_src = (op == `OP_LUI);
            end
            default: begin
                reg_write = 1'b0;
                mem_write = 1'b0;
            end
        endcase
    end

    // ALU decoder
    always_comb begin
        alu_ctrl = `ALU_ADD;
        case (alu_class)
            CLASS_ARITH: begin
                case (funct3)
                    3'b000: begin
                        // SUB only exists in the register form
                        if (op == `OP_ALU_REG && funct7[5]) begin
                            alu_ctrl = `ALU_SUB;
                        end else begin
                            alu_ctrl = `ALU_ADD;
                        end
                    end
                    3'b001:  alu_ctrl = `ALU_SLL;
                    3'b010:  alu_ctrl = `ALU_SLT;
                    3'b011:  alu_ctrl = `ALU_SLTU;
                    3'b100:  alu_ctrl = `ALU_XOR;
                    3'b101:  alu_ctrl = funct7[5] ? `ALU_SRA : `ALU_SRL;
                    3'b110:  alu_ctrl = `ALU_OR;
                    default: alu_ctrl = `ALU_AND;
                endcase
            end
            CLASS_BRANCH: begin
                case (funct3)
                    3'b000, 3'b001: alu_ctrl = `ALU_SUB;
                    3'b100, 3'b101: alu_ctrl = `ALU_SLT;
                    default:        alu_ctrl = `ALU_ADD;
                endcase
            end
            default: alu_ctrl = `ALU_ADD;
        endcase
    end

    // Branch decision from ALU flags
    always_comb begin
        case (funct3)
            3'b000:  take_branch = alu_zero;
            3'b001:  take_branch = ~alu_zero;
            3'b100:  take_branch = alu_last_bit;
            3'b101:  take_branch = ~alu_last_bit;
            default: take_branch = 1'b0;
        endcase
    end

    assign pc_src = (branch & take_branch) | jump;

endmodule

//--- hw/datapath/alu.sv
`timescale 1ns/1ns

`include "rv_defines.svh"

module alu (
    input  rv_pkg::word_t       a,
    input  rv_pkg::word_t       b,
    input  rv_pkg::alu_ctrl_t   alu_ctrl,
    output rv_pkg::word_t       result,
    output logic                zero,
    output logic                last_bit
);

    import rv_pkg::*;

    logic [4:0] shamt;
    word_t      sum;
    word_t      diff;

    assign shamt = b[4:0];
    assign sum   = a + b;
    assign diff  = a - b;

    always_comb begin
        case (alu_ctrl)
            `ALU_ADD:  result = sum;
            `ALU_SUB:  result = diff;
            `ALU_AND:  result = a & b;
            `ALU_OR:   result = a | b;
            `ALU_XOR:  result = a ^ b;
            `ALU_SLL:  result = a << shamt;
            `ALU_SRL:  result = a >> shamt;
            `ALU_SRA:  result = word_t'($signed(a) >>> shamt);
            // Compare results are a single bit in the LSB
            `ALU_SLT:  result = {31'b0, $signed(a) < $signed(b)};
            `ALU_SLTU: result = {31'b0, a < b};
            default:   result = '0;
        endcase
    end

    assign zero     = (result == '0);
    assign last_bit = result[0];

endmodule

//--- hw/datapath/reg_file.sv
`timescale 1ns/1ns

module reg_file (
    input  logic                clk,
    input  logic                rst_n,
    input  rv_pkg::reg_idx_t    raddr1,
    input  rv_pkg::reg_idx_t    raddr2,
    input  rv_pkg::reg_idx_t    waddr,
    input  rv_pkg::word_t       wdata,
    input  logic                we,
    output rv_pkg::word_t       rdata1,
    output rv_pkg::word_t       rdata2
);

    import rv_pkg::*;

    word_t regs [32];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (we && waddr != '0) begin
            regs[waddr] <= wdata;
        end
    end

    // x0 reads as zero whatever is stored
    assign rdata1 = (raddr1 == '0) ? '0 : regs[raddr1];
    assign rdata2 = (raddr2 == '0) ? '0 : regs[raddr2];

endmodule

//--- hw/datapath/imm_gen.sv
`timescale 1ns/1ns

`include "rv_defines.svh"

module imm_gen (
    input  rv_pkg::word_t       instr,
    input  rv_pkg::imm_src_t    imm_src,
    output rv_pkg::word_t       imm
);

    always_comb begin
        case (imm_src)
            `IMM_I: imm = {{20{instr[31]}}, instr[31:20]};
            `IMM_S: imm = {{20{instr[31]}}, instr[31:25], instr[11:7]};
            // Branch and jump offsets are in half-words, bit 0 is always zero
            `IMM_B: imm = {{20{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
            `IMM_J: begin
                imm = {{12{instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};
            end
            `IMM_U: imm = {instr[31:12], 12'b0};
            default: imm = '0;
        endcase
    end

endmodule

//--- hw/cpu_core.sv
`timescale 1ns/1ns

`include "rv_defines.svh"

module cpu_core (
    input  logic            clk,
    input  logic            rst_n,
    input  rv_pkg::word_t   instr,
    input  rv_pkg::word_t   mem_rdata,
    output rv_pkg::word_t   pc,
    output rv_pkg::word_t   mem_addr,
    output rv_pkg::word_t   mem_wdata,
    output logic            mem_we
);

    import rv_pkg::*;

    // Instruction fields
    reg_idx_t  rs1;
    reg_idx_t  rs2;
    reg_idx_t  rd;

    // Control outputs
    alu_ctrl_t alu_ctrl;
    imm_src_t  imm_src;
    wb_src_t   wb_src;
    logic      mem_write;
    logic      reg_write;
    logic      alu_src;
    logic      pc_src;
    logic      upper_src;

    // Datapath
    word_t     imm;
    word_t     rdata1;
    word_t     rdata2;
    word_t     alu_b;
    word_t     alu_result;
    logic      alu_zero;
    logic      alu_last_bit;
    word_t     wb_data;
    word_t     pc_plus4;
    word_t     pc_target;
    word_t     upper_base;
    word_t     upper_sum;
    word_t     pc_next;

    assign rs1 = instr[19:15];
    assign rs2 = instr[24:20];
    assign rd  = instr[11:7];

    // PC register
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pc <= `RESET_PC;
        end else begin
            pc <= pc_next;
        end
    end

    assign pc_plus4  = pc + 32'd4;
    assign pc_target = pc + imm;
    assign pc_next   = pc_src ? pc_target : pc_plus4;

    // LUI adds to zero, AUIPC to the PC
    assign upper_base = upper_src ? '0 : pc;
    assign upper_sum  = upper_base + imm;

    assign alu_b = alu_src ? imm : rdata2;

    always_comb begin
        case (wb_src)
            `WB_MEM: wb_data = mem_rdata;
            `WB_PC4: wb_data = pc_plus4;
            `WB_UPPER: wb_data = upper_sum;
            default: wb_data = alu_result;
        endcase
    end

    // Data memory port
    assign mem_addr  = alu_result;
    assign mem_wdata = rdata2;
    assign mem_we    = mem_write & rst_n;

    control control_inst (
        .op           (instr[6:0]),
        .funct3       (instr[14:12]),
        .funct7       (instr[31:25]),
        .alu_zero     (alu_zero),
        .alu_last_bit (alu_last_bit),
        .alu_ctrl     (alu_ctrl),
        .imm_src      (imm_src),
        .mem_write    (mem_write),
        .reg_write    (reg_write),
        .alu_src      (alu_src),
        .wb_src       (wb_src),
        .pc_src       (pc_src),
        .upper_src    (upper_src)
    );

    reg_file reg_file_inst (
        .clk    (clk),
        .rst_n  (rst_n),
        .raddr1 (rs1),
        .raddr2 (rs2),
        .waddr  (rd),
        .wdata  (wb_data),
        .we     (reg_write),
        .rdata1 (rdata1),
        .rdata2 (rdata2)
    );

    imm_gen imm_gen_inst (
        .instr   (instr),
        .imm_src (imm_src),
        .imm     (imm)
    );

    alu alu_inst (
        .a        (rdata1),
        .b        (alu_b),
        .alu_ctrl (alu_ctrl),
        .result   (alu_result),
        .zero     (alu_zero),
        .last_bit (alu_last_bit)
    );

endmodule

//--- verification/store_checker.sv
`timescale 1ns/1ns

`include "rv_defines.svh"

module store_checker (
    input  logic            clk,
    input  logic            rst_n,
    input  rv_pkg::word_t   pc,
    input  logic            mem_we,
    input  rv_pkg::word_t   mem_addr,
    input  rv_pkg::word_t   mem_wdata
);

    import rv_pkg::*;

    localparam int NUM_TESTS  = 6;
    localparam int MAX_STORES = 64;

    // Expected stores in program order
    int    exp_test [MAX_STORES];
    word_t exp_addr [MAX_STORES];
    word_t exp_data [MAX_STORES];
    int    exp_count    = 0;
    int    seen         = 0;
    int    cur_test     = 1;
    int    test_errs    = 0;
    int    tests_passed = 0;
    int    tests_failed = 0;
    bit    started      = 1'b0;

    function automatic string test_name(input int t);
        case (t)
            1:       return "reset";
            2:       return "alu";
            3:       return "load";
            4:       return "branch";
            5:       return "jump_upper";
            default: return "decode_suppress";
        endcase
    endfunction

    task automatic add_expected(input int t, input word_t addr, input word_t data);
        if (exp_count < MAX_STORES) begin
            exp_test[exp_count] = t;
            exp_addr[exp_count] = addr;
            exp_data[exp_count] = data;
            exp_count++;
        end
    endtask

    task automatic close_test();
        if (test_errs == 0) begin
            $display("test %0d %s: passed", cur_test, test_name(cur_test));
            tests_passed++;
        end else begin
            $display("test %0d %s: failed with %0d errors", cur_test, test_name(cur_test),
                     test_errs);
            tests_failed++;
        end
        test_errs = 0;
    endtask

    task automatic advance_to(input int t);
        while (cur_test < t) begin
            close_test();
            cur_test++;
        end
    endtask

    always @(posedge clk) begin
        if (!rst_n) begin
            if (mem_we) begin
                $display("Error: store enable is active during reset");
                test_errs++;
            end
        end else begin
            // First active edge fetches from the reset address
            if (!started) begin
                started = 1'b1;
                if (pc !== `RESET_PC) begin
                    $display("FAIL pc expected %h got %h", `RESET_PC, pc);
                    test_errs++;
                end
            end
            if (mem_we) begin
                if (seen >= exp_count) begin
                    $display("Error: extra store to address %h after all expected stores",
                             mem_addr);
                    test_errs++;
                end else begin
                    advance_to(exp_test[seen]);
                    if (mem_addr !== exp_addr[seen]) begin
                        $display("FAIL mem_addr expected %h got %h", exp_addr[seen], mem_addr);
                        test_errs++;
                    end
                    if (mem_wdata !== exp_data[seen]) begin
                        $display("FAIL mem_wdata expected %h got %h", exp_data[seen],
                                 mem_wdata);
                        test_errs++;
                    end
                    seen++;
                end
            end
        end
    end

    task automatic report(output int failed);
        if (seen < exp_count) begin
            advance_to(exp_test[seen]);
            $display("Error: %0d expected stores never happened, first one at address %h",
                     exp_count - seen, exp_addr[seen]);
            test_errs++;
        end
        advance_to(NUM_TESTS);
        close_test();
        $display("Tests: %0d passed, %0d failed", tests_passed, tests_failed);
        failed = tests_failed;
    endtask

endmodule

//--- verification/tb_cpu_core.sv
`timescale 1ns/1ns

module tb_cpu_core;

    import rv_pkg::*;

    localparam int    IMEM_WORDS  = 64;
    localparam int    DMEM_WORDS  = 256;
    localparam int    CLK_PERIOD  = 20;
    localparam word_t HALT_INSTR  = 32'h0000_006f;
    // sw x0, 0(x0), offered while reset is held
    localparam word_t RESET_STORE = 32'h0000_2023;

    logic  clk;
    logic  rst_n;
    word_t pc;
    word_t instr;
    word_t mem_addr;
    word_t mem_wdata;
    word_t mem_rdata;
    logic  mem_we;

    word_t imem [IMEM_WORDS];
    word_t dmem [DMEM_WORDS];
    int    num_instr;
    bit    loaded;
    bit    data_ok;
    int    failed_tests;

    cpu_core cpu_core_inst (
        .clk       (clk),
        .rst_n     (rst_n),
        .instr     (instr),
        .mem_rdata (mem_rdata),
        .pc        (pc),
        .mem_addr  (mem_addr),
        .mem_wdata (mem_wdata),
        .mem_we    (mem_we)
    );

    store_checker store_checker_inst (
        .clk       (clk),
        .rst_n     (rst_n),
        .pc        (pc),
        .mem_we    (mem_we),
        .mem_addr  (mem_addr),
        .mem_wdata (mem_wdata)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    // Combinational memory models
    // Reset presents a store so that the gating of mem_we is visible
    assign instr     = rst_n ? imem[pc[7:2]] : RESET_STORE;
    assign mem_rdata = dmem[mem_addr[9:2]];

    always @(posedge clk) begin
        if (mem_we) begin
            dmem[mem_addr[9:2]] <= mem_wdata;
        end
    end

    task automatic load_testdata(output bit ok);
        int    fd;
        int    n;
        int    test_id;
        string line;
        word_t w [4];
        word_t addr;
        word_t data;
        ok = 1'b0;
        fd = $fopen("verification/cpu_testdata.txt", "r");
        if (fd != 0) begin
            while (!$feof(fd)) begin
                n = $fgets(line, fd);
                if (n > 0) begin
                    n = $sscanf(line, "I %h %h %h %h", w[0], w[1], w[2], w[3]);
                    for (int k = 0; k < n; k++) begin
                        imem[num_instr] = w[k];
                        num_instr++;
                    end
                    if ($sscanf(line, "S %d %h %h", test_id, addr, data) == 3) begin
                        store_checker_inst.add_expected(test_id, addr, data);
                    end
                end
            end
            $fclose(fd);
            ok = 1'b1;
        end
    endtask

    initial begin
        clk       = 1'b0;
        rst_n     = 1'b0;
        loaded    = 1'b0;
        num_instr = 0;
        // Unused words are NOPs that carry their own word index
        for (int i = 0; i < IMEM_WORDS; i++) begin
            imem[i] = (32'(i) << 20) | 32'h0000_0013;
        end
        // Preload pattern follows the byte address
        for (int i = 0; i < DMEM_WORDS; i++) begin
            dmem[i] <= 32'(i * 4) ^ 32'h5a5a_a5a5;
        end
        load_testdata(data_ok);
        if (!data_ok) begin
            $display("Error: cannot open verification/cpu_testdata.txt");
            $display("Test failed");
            $finish;
        end else begin
            loaded = 1'b1;
            repeat (3) @(posedge clk);
            #2;
            rst_n = 1'b1;
            // Run until the final self-jump is fetched
            do begin
                @(posedge clk);
                #1;
            end while (instr != HALT_INSTR);
            store_checker_inst.report(failed_tests);
            if (failed_tests == 0) begin
                $display("Test passed");
            end else begin
                $display("Test failed");
            end
            $finish;
        end
    end

    // Watchdog, four cycles per program word
    initial begin
        int limit_ns;
        wait (loaded);
        limit_ns = num_instr * 4 * CLK_PERIOD;
        #(limit_ns);
        $display("Timeout: the program did not reach its final jump within %0d ns", limit_ns);
        $display("Test failed");
        $finish;
    end

endmodule

//--- verification/cpu_testdata.txt
# I: up to four instruction words in hex, loaded from address 0 upward
# S: test number, expected store address in hex, expected store data in hex
I 10000513 FF900093 00300113 002081B3   # x10=0x100 x1=-7 x2=3, add
I 00352023 402081B3 00352223 0020F1B3   # sub, and
I 00352423 0020E1B3 00352623 0020C1B3   # or, xor
I 00352823 0020A1B3 00352A23 0020B1B3   # slt, sltu
I 00352C23 002091B3 00352E23 0020D1B3   # sll, srl
I 02352023 4020D1B3 02352223 0F00C193   # sra, xori
I 02352423 FFF0B193 02352623 00409193   # sltiu, slli
I 02352823 4010D193 02352A23 07F0F193   # srai, andi
I 02352C23 10052203 00120213 02452E23   # lw from 0x200, addi, sw
I 00108463 00152023 00208463 04252023   # beq taken, beq not taken
I 00209463 00152023 00109463 04252223   # bne taken, bne not taken
I 0020C463 00152023 00114463 04252423   # blt taken, blt not taken
I 00115463 00152023 0020D463 04252623   # bge taken, bge not taken
I 0080036F 00152023 04652823 123453B7   # jal x6, lui x7
I 04752A23 00001417 04852C23 40409113   # auipc x8, slli with bad funct7
I 0000017F 04252E23 0000006F            # unknown opcode, final self-jump
S 2 00000100 FFFFFFFC   # add
S 2 00000104 FFFFFFF6   # sub
S 2 00000108 00000001   # and
S 2 0000010C FFFFFFFB   # or
S 2 00000110 FFFFFFFA   # xor
S 2 00000114 00000001   # slt
S 2 00000118 00000000   # sltu
S 2 0000011C FFFFFFC8   # sll
S 2 00000120 1FFFFFFF   # srl
S 2 00000124 FFFFFFFF   # sra
S 2 00000128 FFFFFF09   # xori
S 2 0000012C 00000001   # sltiu
S 2 00000130 FFFFFF90   # slli
S 2 00000134 FFFFFFFC   # srai
S 2 00000138 00000079   # andi
S 3 0000013C 5A5AA7A6   # preloaded word plus one
S 4 00000140 00000003   # after beq pair
S 4 00000144 00000003   # after bne pair
S 4 00000148 00000003   # after blt pair
S 4 0000014C 00000003   # after bge pair
S 5 00000150 000000D4   # jal link
S 5 00000154 12345000   # lui
S 5 00000158 000010E4   # auipc
S 6 0000015C 00000003   # x2 unchanged

//--- filelist.f
+incdir+common
common/rv_pkg.sv
hw/control/control.sv
hw/datapath/alu.sv
hw/datapath/reg_file.sv
hw/datapath/imm_gen.sv
hw/cpu_core.sv
verification/store_checker.sv
verification/tb_cpu_core.sv

//--- Makefile
.PHONY: all lint clean

all:
	verilator --binary --timing -f filelist.f --top-module tb_cpu_core -o sim
	./obj_dir/sim | tee /dev/stderr | grep -q '^Test passed$$'

lint:
	verilator --lint-only --timing -f filelist.f --top-module tb_cpu_core

clean:
	rm -rf obj_dir
